//--- hdl/rv_isa_pkg.sv
// RV32I subset encodings: word and index types, major opcodes, funct3 values
package rv_isa_pkg;

	localparam int XLEN     = 32;
	localparam int NUM_REGS = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_idx_t;
	// byte address without its two low bits
	typedef logic [XLEN-3:0] mem_addr_t;
	typedef logic [6:0]      opcode_t;
	typedef logic [2:0]      funct3_t;

	localparam opcode_t OP_RTYPE  = 7'b0110011;
	localparam opcode_t OP_ITYPE  = 7'b0010011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;

	// alu group, shared by register and immediate forms
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// branch conditions
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

endpackage

//--- hdl/rv_pipe_pkg.sv
// pipeline-internal definitions: ALU operation codes, forward selects, nop word
package rv_pipe_pkg;

	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_XOR  = 4'd2;
	localparam alu_op_t ALU_OR   = 4'd3;
	localparam alu_op_t ALU_AND  = 4'd4;
	localparam alu_op_t ALU_SLL  = 4'd5;
	localparam alu_op_t ALU_SRL  = 4'd6;
	localparam alu_op_t ALU_SRA  = 4'd7;
	localparam alu_op_t ALU_SLT  = 4'd8;
	localparam alu_op_t ALU_SLTU = 4'd9;

	// operand source seen by decode
	typedef logic [1:0] fwd_sel_t;

	// register file output, no hazard
	localparam fwd_sel_t FWD_REG = 2'd0;
	// value being written back this cycle
	localparam fwd_sel_t FWD_WB  = 2'd1;
	// memory stage result, loaded word included
	localparam fwd_sel_t FWD_MEM = 2'd2;
	// result of the instruction in execute
	localparam fwd_sel_t FWD_EX  = 2'd3;

	// addi x0, x0, 0
	localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

//--- hdl/rv_fetch_decode.sv
// fetch and decode stages: PC, instruction register, immediates, control decode, forwarding
`timescale 1ns/1ps

module rv_fetch_decode
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  logic      Clk,
	input  logic      rst_n,
	input  word_t     i_imem_rdata,
	input  logic      i_stall,
	input  logic      i_redirect,
	input  word_t     i_redirect_pc,
	input  fwd_sel_t  i_fwd_rs1,
	input  fwd_sel_t  i_fwd_rs2,
	input  word_t     i_rs1_data,
	input  word_t     i_rs2_data,
	input  word_t     i_ex_result,
	input  word_t     i_mem_result,
	input  word_t     i_wb_data,
	output mem_addr_t o_imem_addr,
	output reg_idx_t  o_rs1,
	output reg_idx_t  o_rs2,
	output reg_idx_t  o_rd,
	output word_t     o_op_a,
	output word_t     o_op_b,
	output word_t     o_store_data,
	output word_t     o_pc,
	output alu_op_t   o_alu_op,
	output funct3_t   o_funct3,
	output logic      o_is_branch,
	output logic      o_is_jal,
	output logic      o_is_jalr,
	output logic      o_is_load,
	output logic      o_is_store,
	output logic      o_reg_write
);

	word_t   pc;
	word_t   pc_id;
	word_t   ir;
	opcode_t opcode;
	funct3_t funct3;
	logic    is_rtype;
	logic    is_itype;
	logic    is_load;
	logic    is_store;
	logic    is_branch;
	logic    is_jal;
	logic    is_jalr;
	logic    use_imm;
	word_t   imm_i;
	word_t   imm_s;
	word_t   imm_b;
	word_t   imm_j;
	word_t   imm;
	word_t   rs1_fwd;
	word_t   rs2_fwd;
	alu_op_t alu_op;

	function automatic word_t fwd_mux(
		input fwd_sel_t sel,
		input word_t    reg_val,
		input word_t    ex_val,
		input word_t    mem_val,
		input word_t    wb_val
	);
		case (sel)
			FWD_EX:  return ex_val;
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// pc and ir hold on a load-use stall, redirect wins
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			pc <= '0;
			ir <= NOP_INSTR;
		end else if (i_redirect) begin
			pc <= i_redirect_pc;
			ir <= NOP_INSTR;
		end else if (!i_stall) begin
			pc <= pc + 32'd4;
			ir <= i_imem_rdata;
		end
	end

	// address of the word now in ir
	always_ff @(posedge Clk) begin
		if (!i_stall) begin
			pc_id <= pc;
		end
	end

	assign o_imem_addr = pc[XLEN-1:2];

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign o_rs1  = ir[19:15];
	assign o_rs2  = ir[24:20];

	assign is_rtype  = (opcode == OP_RTYPE);
	assign is_itype  = (opcode == OP_ITYPE);
	assign is_load   = (opcode == OP_LOAD);
	assign is_store  = (opcode == OP_STORE);
	assign is_branch = (opcode == OP_BRANCH);
	assign is_jal    = (opcode == OP_JAL);
	assign is_jalr   = (opcode == OP_JALR);

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	assign imm = is_store  ? imm_s :
		is_branch ? imm_b :
		is_jal    ? imm_j : imm_i;

	// ir[30] selects sub and sra
	always_comb begin
		alu_op = ALU_ADD;
		if (is_rtype || is_itype) begin
			case (funct3)
				F3_ADD:  alu_op = (is_rtype && ir[30]) ? ALU_SUB : ALU_ADD;
				F3_SLL:  alu_op = ALU_SLL;
				F3_SLT:  alu_op = ALU_SLT;
				F3_SLTU: alu_op = ALU_SLTU;
				F3_XOR:  alu_op = ALU_XOR;
				F3_SR:   alu_op = ir[30] ? ALU_SRA : ALU_SRL;
				F3_OR:   alu_op = ALU_OR;
				F3_AND:  alu_op = ALU_AND;
				default: alu_op = ALU_ADD;
			endcase
		end
	end

	assign rs1_fwd = fwd_mux(i_fwd_rs1, i_rs1_data, i_ex_result, i_mem_result, i_wb_data);
	assign rs2_fwd = fwd_mux(i_fwd_rs2, i_rs2_data, i_ex_result, i_mem_result, i_wb_data);
	assign use_imm = !(is_rtype || is_branch || is_jal || is_jalr);

	// cleared flags make a bubble in execute
	always_ff @(posedge Clk) begin
		if (!rst_n || i_stall || i_redirect) begin
			o_is_branch <= 1'b0;
			o_is_jal    <= 1'b0;
			o_is_jalr   <= 1'b0;
			o_is_load   <= 1'b0;
			o_is_store  <= 1'b0;
			o_reg_write <= 1'b0;
		end else begin
			o_is_branch <= is_branch;
			o_is_jal    <= is_jal;
			o_is_jalr   <= is_jalr;
			o_is_load   <= is_load;
			o_is_store  <= is_store;
			o_reg_write <= is_rtype || is_itype || is_load || is_jal || is_jalr;
		end
	end

	// store data slot carries the target offset for branches and jumps
	always_ff @(posedge Clk) begin
		o_rd         <= ir[11:7];
		o_pc         <= pc_id;
		o_alu_op     <= alu_op;
		o_funct3     <= funct3;
		o_op_a       <= rs1_fwd;
		o_op_b       <= use_imm ? imm : rs2_fwd;
		o_store_data <= is_store ? rs2_fwd : imm;
	end

endmodule

//--- hdl/rv_reg_file.sv
// 32 by 32 register file, two combinational read ports and one clocked write port
`timescale 1ns/1ps

module rv_reg_file
	import rv_isa_pkg::*;
(
	input  logic     Clk,
	input  logic     rst_n,
	input  reg_idx_t i_rs1,
	input  reg_idx_t i_rs2,
	input  reg_idx_t i_wr_idx,
	input  logic     i_wr_en,
	input  word_t    i_wr_data,
	output word_t    o_rs1_data,
	output word_t    o_rs2_data
);

	word_t regs [NUM_REGS];

	// writes to x0 are dropped
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && (i_wr_idx != '0)) begin
			regs[i_wr_idx] <= i_wr_data;
		end
	end

	// x0 reads zero
	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- hdl/rv_hazard_unit.sv
// forwarding select per source operand and load-use stall detection
`timescale 1ns/1ps

module rv_hazard_unit
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  reg_idx_t i_rs1,
	input  reg_idx_t i_rs2,
	input  reg_idx_t i_ex_rd,
	input  reg_idx_t i_mem_rd,
	input  reg_idx_t i_wb_rd,
	input  logic     i_ex_wen,
	input  logic     i_mem_wen,
	input  logic     i_wb_wen,
	input  logic     i_ex_is_load,
	output fwd_sel_t o_fwd_rs1,
	output fwd_sel_t o_fwd_rs2,
	output logic     o_stall
);

	// youngest writer wins, x0 never forwards
	function automatic fwd_sel_t pick_fwd(input reg_idx_t rs);
		if (i_ex_wen && (i_ex_rd != '0) && (i_ex_rd == rs)) begin
			return FWD_EX;
		end else if (i_mem_wen && (i_mem_rd != '0) && (i_mem_rd == rs)) begin
			return FWD_MEM;
		end else if (i_wb_wen && (i_wb_rd != '0) && (i_wb_rd == rs)) begin
			return FWD_WB;
		end else begin
			return FWD_REG;
		end
	endfunction

	assign o_fwd_rs1 = pick_fwd(i_rs1);
	assign o_fwd_rs2 = pick_fwd(i_rs2);

	// load data only exists from the memory stage on
	assign o_stall = i_ex_is_load && (i_ex_rd != '0) &&
		((i_ex_rd == i_rs1) || (i_ex_rd == i_rs2));

endmodule

//--- hdl/rv_execute.sv
// execute, memory and write-back stages: ALU, branch compare, redirect, data memory port
`timescale 1ns/1ps

module rv_execute
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  logic      Clk,
	input  logic      rst_n,
	input  reg_idx_t  i_rd,
	input  word_t     i_op_a,
	input  word_t     i_op_b,
	input  word_t     i_store_data,
	input  word_t     i_pc,
	input  alu_op_t   i_alu_op,
	input  funct3_t   i_funct3,
	input  logic      i_is_branch,
	input  logic      i_is_jal,
	input  logic      i_is_jalr,
	input  logic      i_is_load,
	input  logic      i_is_store,
	input  logic      i_reg_write,
	input  word_t     i_dmem_rdata,
	output logic      o_redirect,
	output word_t     o_redirect_pc,
	output word_t     o_ex_result,
	output word_t     o_mem_result,
	output reg_idx_t  o_ex_rd,
	output reg_idx_t  o_mem_rd,
	output reg_idx_t  o_wb_rd,
	output logic      o_ex_wen,
	output logic      o_mem_wen,
	output logic      o_wb_wen,
	output logic      o_ex_is_load,
	output word_t     o_wb_data,
	output logic      o_dmem_ren,
	output logic      o_dmem_wen,
	output mem_addr_t o_dmem_addr,
	output word_t     o_dmem_wdata
);

	logic [4:0] shamt;
	word_t      alu_out;
	logic       br_taken;
	logic       is_jump;
	word_t      target;
	word_t      mem_alu;
	word_t      mem_wdata;
	logic       mem_is_load;
	logic       mem_is_store;

	assign shamt = i_op_b[4:0];

	always_comb begin
		case (i_alu_op)
			ALU_SUB:  alu_out = i_op_a - i_op_b;
			ALU_XOR:  alu_out = i_op_a ^ i_op_b;
			ALU_OR:   alu_out = i_op_a | i_op_b;
			ALU_AND:  alu_out = i_op_a & i_op_b;
			ALU_SLL:  alu_out = i_op_a << shamt;
			ALU_SRL:  alu_out = i_op_a >> shamt;
			ALU_SRA:  alu_out = word_t'($signed(i_op_a) >>> shamt);
			ALU_SLT:  alu_out = word_t'($signed(i_op_a) < $signed(i_op_b));
			ALU_SLTU: alu_out = word_t'(i_op_a < i_op_b);
			default:  alu_out = i_op_a + i_op_b;
		endcase
	end

	always_comb begin
		case (i_funct3)
			F3_BEQ:  br_taken = (i_op_a == i_op_b);
			F3_BNE:  br_taken = (i_op_a != i_op_b);
			F3_BLT:  br_taken = ($signed(i_op_a) < $signed(i_op_b));
			F3_BGE:  br_taken = ($signed(i_op_a) >= $signed(i_op_b));
			F3_BLTU: br_taken = (i_op_a < i_op_b);
			F3_BGEU: br_taken = (i_op_a >= i_op_b);
			default: br_taken = 1'b0;
		endcase
	end

	// jumps write back the link value
	assign is_jump     = i_is_jal || i_is_jalr;
	assign o_ex_result = is_jump ? (i_pc + 32'd4) : alu_out;

	// offset arrives in the store data slot
	assign target        = (i_is_jalr ? i_op_a : i_pc) + i_store_data;
	assign o_redirect    = is_jump || (i_is_branch && br_taken);
	assign o_redirect_pc = {target[XLEN-1:1], 1'b0};

	assign o_ex_rd      = i_rd;
	assign o_ex_wen     = i_reg_write;
	assign o_ex_is_load = i_is_load;

	// memory stage
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			o_mem_wen    <= 1'b0;
			mem_is_load  <= 1'b0;
			mem_is_store <= 1'b0;
		end else begin
			o_mem_wen    <= i_reg_write;
			mem_is_load  <= i_is_load;
			mem_is_store <= i_is_store;
		end
	end

	always_ff @(posedge Clk) begin
		o_mem_rd  <= i_rd;
		mem_alu   <= o_ex_result;
		mem_wdata <= i_store_data;
	end

	assign o_dmem_ren   = mem_is_load;
	assign o_dmem_wen   = mem_is_store;
	assign o_dmem_addr  = mem_alu[XLEN-1:2];
	assign o_dmem_wdata = mem_wdata;

	// loaded word replaces the address here
	assign o_mem_result = mem_is_load ? i_dmem_rdata : mem_alu;

	// write-back stage
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			o_wb_wen <= 1'b0;
		end else begin
			o_wb_wen <= o_mem_wen;
		end
	end

	always_ff @(posedge Clk) begin
		o_wb_rd   <= o_mem_rd;
		o_wb_data <= o_mem_result;
	end

endmodule

//--- hdl/rv_core.sv
// five-stage RV32I core top level with instruction and data memory ports
`timescale 1ns/1ps

module rv_core
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;
(
	input  logic      Clk,
	input  logic      rst_n,
	input  word_t     i_imem_rdata,
	input  word_t     i_dmem_rdata,
	output mem_addr_t o_imem_addr,
	output logic      o_dmem_ren,
	output logic      o_dmem_wen,
	output mem_addr_t o_dmem_addr,
	output word_t     o_dmem_wdata
);

	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t id_rd;
	reg_idx_t ex_rd;
	reg_idx_t mem_rd;
	reg_idx_t wb_rd;
	word_t    rs1_data;
	word_t    rs2_data;
	word_t    op_a;
	word_t    op_b;
	word_t    store_data;
	word_t    id_pc;
	word_t    ex_result;
	word_t    mem_result;
	word_t    wb_data;
	word_t    redirect_pc;
	alu_op_t  alu_op;
	funct3_t  funct3;
	fwd_sel_t fwd_rs1;
	fwd_sel_t fwd_rs2;
	logic     is_branch;
	logic     is_jal;
	logic     is_jalr;
	logic     is_load;
	logic     is_store;
	logic     reg_write;
	logic     stall;
	logic     redirect;
	logic     ex_wen;
	logic     mem_wen;
	logic     wb_wen;
	logic     ex_is_load;

	rv_fetch_decode u_fetch_decode (
		.Clk           (Clk),
		.rst_n         (rst_n),
		.i_imem_rdata  (i_imem_rdata),
		.i_stall       (stall),
		.i_redirect    (redirect),
		.i_redirect_pc (redirect_pc),
		.i_fwd_rs1     (fwd_rs1),
		.i_fwd_rs2     (fwd_rs2),
		.i_rs1_data    (rs1_data),
		.i_rs2_data    (rs2_data),
		.i_ex_result   (ex_result),
		.i_mem_result  (mem_result),
		.i_wb_data     (wb_data),
		.o_imem_addr   (o_imem_addr),
		.o_rs1         (rs1),
		.o_rs2         (rs2),
		.o_rd          (id_rd),
		.o_op_a        (op_a),
		.o_op_b        (op_b),
		.o_store_data  (store_data),
		.o_pc          (id_pc),
		.o_alu_op      (alu_op),
		.o_funct3      (funct3),
		.o_is_branch   (is_branch),
		.o_is_jal      (is_jal),
		.o_is_jalr     (is_jalr),
		.o_is_load     (is_load),
		.o_is_store    (is_store),
		.o_reg_write   (reg_write)
	);

	// written from the write-back stage
	rv_reg_file u_reg_file (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.i_rs1      (rs1),
		.i_rs2      (rs2),
		.i_wr_idx   (wb_rd),
		.i_wr_en    (wb_wen),
		.i_wr_data  (wb_data),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	rv_hazard_unit u_hazard (
		.i_rs1        (rs1),
		.i_rs2        (rs2),
		.i_ex_rd      (ex_rd),
		.i_mem_rd     (mem_rd),
		.i_wb_rd      (wb_rd),
		.i_ex_wen     (ex_wen),
		.i_mem_wen    (mem_wen),
		.i_wb_wen     (wb_wen),
		.i_ex_is_load (ex_is_load),
		.o_fwd_rs1    (fwd_rs1),
		.o_fwd_rs2    (fwd_rs2),
		.o_stall      (stall)
	);

	rv_execute u_execute (
		.Clk           (Clk),
		.rst_n         (rst_n),
		.i_rd          (id_rd),
		.i_op_a        (op_a),
		.i_op_b        (op_b),
		.i_store_data  (store_data),
		.i_pc          (id_pc),
		.i_alu_op      (alu_op),
		.i_funct3      (funct3),
		.i_is_branch   (is_branch),
		.i_is_jal      (is_jal),
		.i_is_jalr     (is_jalr),
		.i_is_load     (is_load),
		.i_is_store    (is_store),
		.i_reg_write   (reg_write),
		.i_dmem_rdata  (i_dmem_rdata),
		.o_redirect    (redirect),
		.o_redirect_pc (redirect_pc),
		.o_ex_result   (ex_result),
		.o_mem_result  (mem_result),
		.o_ex_rd       (ex_rd),
		.o_mem_rd      (mem_rd),
		.o_wb_rd       (wb_rd),
		.o_ex_wen      (ex_wen),
		.o_mem_wen     (mem_wen),
		.o_wb_wen      (wb_wen),
		.o_ex_is_load  (ex_is_load),
		.o_wb_data     (wb_data),
		.o_dmem_ren    (o_dmem_ren),
		.o_dmem_wen    (o_dmem_wen),
		.o_dmem_addr   (o_dmem_addr),
		.o_dmem_wdata  (o_dmem_wdata)
	);

endmodule

//--- verif/rv_core_properties.sv
// bound assertions on the data memory port and the fetch stall behavior
`timescale 1ns/1ps

module rv_core_properties
	import rv_isa_pkg::*;
(
	input logic      Clk,
	input logic      rst_n,
	input logic      i_dmem_ren,
	input logic      i_dmem_wen,
	input mem_addr_t i_imem_addr,
	input logic      i_stall
);

	// one data access per cycle
	assert property (@(posedge Clk) disable iff (!rst_n) !(i_dmem_ren && i_dmem_wen))
		else $error("data memory read and write enabled together");

	assert property (@(posedge Clk) $rose(rst_n) |-> (!i_dmem_ren && !i_dmem_wen))
		else $error("data memory access active right after reset");

	// load-use stall freezes the PC
	assert property (@(posedge Clk) disable iff (!rst_n) i_stall |=> $stable(i_imem_addr))
		else $error("instruction address moved across a stall cycle");

endmodule

bind rv_core rv_core_properties u_props (
	.Clk         (Clk),
	.rst_n       (rst_n),
	.i_dmem_ren  (o_dmem_ren),
	.i_dmem_wen  (o_dmem_wen),
	.i_imem_addr (o_imem_addr),
	.i_stall     (stall)
);

//--- verif/tb_rv_core.sv
// testbench for rv_core: clock, reset, memory models, trace loading, store checks, report
`timescale 1ns/1ps

module tb_rv_core
	import rv_isa_pkg::*;
();

	localparam int    MEM_WORDS  = 256;
	localparam int    DRAIN      = 8;
	localparam string TRACE_FILE = "verif/rv_core_trace.txt";

	logic      Clk;
	logic      rst_n;
	word_t     imem_rdata;
	word_t     dmem_rdata;
	mem_addr_t imem_addr;
	mem_addr_t dmem_addr;
	logic      dmem_ren;
	logic      dmem_wen;
	word_t     dmem_wdata;

	word_t     imem [MEM_WORDS];
	word_t     dmem [MEM_WORDS];
	string     exp_name [$];
	mem_addr_t exp_addr [$];
	word_t     exp_data [$];
	int        instr_count;
	int        errors;
	int        passed;
	mem_addr_t halt_addr;

	rv_core u_dut (
		.Clk          (Clk),
		.rst_n        (rst_n),
		.i_imem_rdata (imem_rdata),
		.i_dmem_rdata (dmem_rdata),
		.o_imem_addr  (imem_addr),
		.o_dmem_ren   (dmem_ren),
		.o_dmem_wen   (dmem_wen),
		.o_dmem_addr  (dmem_addr),
		.o_dmem_wdata (dmem_wdata)
	);

	// both memories answer in the same cycle
	assign imem_rdata = imem[imem_addr[7:0]];
	// data word only while the read strobe is high
	assign dmem_rdata = dmem_ren ? dmem[dmem_addr[7:0]] : '0;

	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	task automatic check_addr(input string name, input mem_addr_t expected,
		input mem_addr_t actual, output bit ok);
		ok = (expected == actual);
		if (!ok) begin
			$display("FAIL %s address expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_word(input string name, input word_t expected,
		input word_t actual, output bit ok);
		ok = (expected == actual);
		if (!ok) begin
			$display("FAIL %s data expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic load_trace();
		int    fd;
		int    n;
		string line;
		string tag;
		string name;
		word_t a;
		word_t w;
		byte   c;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open trace file %s", TRACE_FILE);
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() == 0) begin
				continue;
			end
			c = line.getc(0);
			if (c == "I" || c == "D") begin
				n = $sscanf(line, "%s %h %h", tag, a, w);
				if (n != 3) begin
					$display("malformed trace line: %s", line);
					errors++;
				end else if (c == "I") begin
					imem[a[9:2]] = w;
					instr_count++;
					if (a[31:2] > halt_addr) begin
						halt_addr = a[31:2];
					end
				end else begin
					dmem[a[9:2]] = w;
				end
			end else if (c == "E") begin
				n = $sscanf(line, "%s %s %h %h", tag, name, a, w);
				if (n != 4) begin
					$display("malformed trace line: %s", line);
					errors++;
				end else begin
					exp_name.push_back(name);
					exp_addr.push_back(mem_addr_t'(a));
					exp_data.push_back(w);
				end
			end
		end
		$fclose(fd);
	endtask

	// one expected entry per store, in program order
	task automatic compare_store(input mem_addr_t a, input word_t d);
		bit    a_ok;
		bit    d_ok;
		string name;
		if (exp_name.size() == 0) begin
			$display("unexpected store of %h to word address %h with no expected store left",
				d, a);
			errors++;
		end else begin
			name = exp_name.pop_front();
			check_addr(name, exp_addr.pop_front(), a, a_ok);
			check_word(name, exp_data.pop_front(), d, d_ok);
			if (a_ok && d_ok) begin
				passed++;
				$display("ok   %s", name);
			end else begin
				errors++;
			end
		end
	endtask

	always @(negedge Clk) begin
		if (rst_n && dmem_wen) begin
			compare_store(dmem_addr, dmem_wdata);
			dmem[dmem_addr[7:0]] = dmem_wdata;
		end
	end

	initial begin
		int  cycle_limit;
		int  cycles;
		int  drain;
		bit  halt_seen;
		rst_n       = 1'b0;
		errors      = 0;
		passed      = 0;
		instr_count = 0;
		halt_addr   = '0;
		cycles      = 0;
		drain       = 0;
		halt_seen   = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = 32'h0000_0013;
			dmem[i] = (word_t'(i) * 32'h0001_0101) ^ 32'hc3c3_0000;
		end
		load_trace();
		cycle_limit = 4 * instr_count + 100;
		repeat (3) @(posedge Clk);
		rst_n <= 1'b1;
		// run until the final self loop is fetched, then let the pipe drain
		while (drain < DRAIN && cycles < cycle_limit) begin
			@(negedge Clk);
			cycles++;
			if (imem_addr == halt_addr) begin
				halt_seen = 1'b1;
			end
			if (halt_seen) begin
				drain++;
			end
		end
		if (drain < DRAIN) begin
			$display("timeout after %0d cycles, end of program never reached", cycles);
			errors++;
		end
		if (exp_name.size() != 0) begin
			$display("%0d expected stores never happened, first missing is %s",
				exp_name.size(), exp_name[0]);
			errors++;
		end
		$display("%0d tests passed, %0d errors", passed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- verif/rv_core_trace.txt
# I <byte address> <instruction word>   D <byte address> <data word>
# E <test name> <expected store word address> <expected store data>
I 00000000 FFB00093
I 00000004 00300113
I 00000008 402081B3
I 0000000C 4021D233
I 00000010 0020A2B3
I 00000014 0020B333
I 00000018 0020C3B3
I 0000001C 10302023
I 00000020 10402223
I 00000024 10502423
I 00000028 10602623
I 0000002C 10702823
I 00000030 00A10413
I 00000034 008404B3
I 00000038 00249513
I 0000003C 10A02A23
I 00000040 20002583
I 00000044 00258633
I 00000048 10C02C23
I 0000004C 00210663
I 00000050 1E002823
I 00000054 1E002823
I 00000058 00208463
I 0000005C 10202E23
I 00000060 00209663
I 00000064 1E002823
I 00000068 1E002823
I 0000006C 00211463
I 00000070 12202023
I 00000074 0020C663
I 00000078 1E002823
I 0000007C 1E002823
I 00000080 00114463
I 00000084 12202223
I 00000088 00115663
I 0000008C 1E002823
I 00000090 1E002823
I 00000094 0020D463
I 00000098 12202423
I 0000009C 00116663
I 000000A0 1E002823
I 000000A4 1E002823
I 000000A8 0020E463
I 000000AC 12202623
I 000000B0 0020F663
I 000000B4 1E002823
I 000000B8 1E002823
I 000000BC 00117463
I 000000C0 12202823
I 000000C4 00C006EF
I 000000C8 1E002823
I 000000CC 1E002823
I 000000D0 12D02A23
I 000000D4 0E400713
I 000000D8 000707E7
I 000000DC 1E002823
I 000000E0 1E002823
I 000000E4 12F02C23
I 000000E8 03700013
I 000000EC 00000833
I 000000F0 13002E23
I 000000F4 14002023
I 000000F8 0000006F
D 00000200 12345678
E sub_neg 00000040 FFFFFFF8
E sra_neg 00000041 FFFFFFFF
E slt_neg 00000042 00000001
E sltu_neg 00000043 00000000
E xor_reg 00000044 FFFFFFF8
E fwd_chain 00000045 00000068
E load_use 00000046 1234567B
E beq_not_taken 00000047 00000003
E bne_not_taken 00000048 00000003
E blt_not_taken 00000049 00000003
E bge_not_taken 0000004A 00000003
E bltu_not_taken 0000004B 00000003
E bgeu_not_taken 0000004C 00000003
E jal_link 0000004D 000000C8
E jalr_link 0000004E 000000DC
E x0_write 0000004F 00000000
E x0_store 00000050 00000000

//--- rv_core.f
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_fetch_decode.sv
hdl/rv_reg_file.sv
hdl/rv_hazard_unit.sv
hdl/rv_execute.sv
hdl/rv_core.sv
verif/rv_core_properties.sv
verif/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core; then
	echo "compile failed"
	exit 1
fi

if ! out=$(./obj_dir/Vtb_rv_core); then
	echo "$out"
	echo "simulation exited with an error"
	exit 1
fi

echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1
